// ==== Bender.yml ====
package:
  name: block_transfer_unit

export_include_dirs:
  - include

sources:
  - hw/blockOpPkg.sv
  - hw/blockStepDecoder.sv
  - hw/blockStepSequencer.sv
  - hw/blockRegUnit.sv
  - hw/blockBusPort.sv
  - hw/blockTransferUnit.sv
  - target: simulation
    files:
      - bench/blockClockGen.sv
      - bench/blockBusModel.sv
      - bench/blockTransferTb.sv

// ==== bench/blockBusModel.sv ====
// Memory and IO bus model
`timescale 1ns/1ps
`default_nettype none

module blockBusModel (
    input  wire        clk,
    input  wire        arstN,
    input  wire        busValid,
    input  wire [15:0] busAddr,
    input  wire        busWrite,
    input  wire        busIo,
    input  wire [7:0]  busWdata,
    input  wire        presetEn,
    input  wire [15:0] presetAddr,
    input  wire [7:0]  presetData,
    output logic       busReady,
    output logic [7:0] busRdata
);

    logic [7:0] mem [0:65535];
    logic [7:0] ioLog [0:255];
    logic [7:0] ioCount;
    logic       waiting;
    logic [1:0] waitCnt;
    logic [1:0] delay;
    integer     seed;
    integer     i;

    // every byte starts as a mix of both address bytes.
    initial begin
        seed = 32'h5e7f_361f;
        for (i = 0; i < 65536; i = i + 1) begin
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
        end
    end

    // IO reads answer with the low port byte scrambled.
    assign busRdata = busIo ? (busAddr[7:0] ^ 8'hA5) : mem[busAddr];

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busReady <= 1'b0;
            waiting  <= 1'b0;
            waitCnt  <= 2'd0;
            ioCount  <= 8'd0;
        end else begin
            if (presetEn) begin
                mem[presetAddr] <= presetData;
            end
            if (busValid && busReady) begin
                busReady <= 1'b0;
                waiting  <= 1'b0;
                if (busWrite && busIo) begin
                    ioLog[ioCount] <= busWdata;
                    ioCount        <= ioCount + 8'd1;
                end else if (busWrite) begin
                    mem[busAddr] <= busWdata;
                end
            end else if (busValid && !waiting) begin
                // a new request waits 0 to 3 extra cycles.
                delay    = $random(seed);
                waiting  <= 1'b1;
                waitCnt  <= delay;
                busReady <= (delay == 2'd0);
            end else if (waiting && !busReady) begin
                if (waitCnt <= 2'd1) begin
                    busReady <= 1'b1;
                end
                waitCnt <= waitCnt - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/blockClockGen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module blockClockGen (
    output logic clk,
    output logic arstN
);

    // 4 ns period.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // release away from the rising edge so the flops see a clean deassertion.
    initial begin
        arstN = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/blockTransferTb.sv ====
// Block transfer unit testbench
`timescale 1ns/1ps
`default_nettype none

module blockTransferTb;

    localparam logic [1:0] CHK_NONE = 2'd0;
    localparam logic [1:0] CHK_MEM  = 2'd1;
    localparam logic [1:0] CHK_IO   = 2'd2;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [15:0] bc;
        logic [15:0] de;
        logic [15:0] hl;
        logic [7:0]  a;
        logic        presetEn;
        logic [15:0] presetAddr;
        logic [7:0]  presetByte;
        logic [15:0] expBc;
        logic [15:0] expDe;
        logic [15:0] expHl;
        logic [7:0]  expA;
        logic [7:0]  expF;
        logic [1:0]  chkKind;
        logic [15:0] chkAddr;
        logic [7:0]  chkByte;
        logic [7:0]  copyLen;
    } entryT;

    wire         clk;
    wire         arstN;
    logic        cmdValid = 1'b0;
    logic [7:0]  cmdOpcode = 8'h00;
    logic [15:0] cmdBc = 16'h0000;
    logic [15:0] cmdDe = 16'h0000;
    logic [15:0] cmdHl = 16'h0000;
    logic [7:0]  cmdA = 8'h00;
    logic        resReady = 1'b0;
    logic        presetEn = 1'b0;
    logic [15:0] presetAddr = 16'h0000;
    logic [7:0]  presetData = 8'h00;
    logic        cmdReady, resValid;
    logic [15:0] resBc, resDe, resHl;
    logic [7:0]  resA, resF;
    logic        busValid, busReady, busWrite, busIo;
    logic [15:0] busAddr;
    logic [7:0]  busWdata, busRdata;

    entryT  entries[$];
    integer seed = 32'h5e7f_361f;
    int     errorCount = 0;
    int     checkCount = 0;
    int     cycleCount = 0;
    int     cycleLimit = 0;

    blockClockGen i_clkGen (.clk(clk), .arstN(arstN));

    blockTransferUnit i_dut (
        .clk(clk), .arstN(arstN), .cmdValid(cmdValid), .cmdReady(cmdReady),
        .cmdOpcode(cmdOpcode), .cmdBc(cmdBc), .cmdDe(cmdDe), .cmdHl(cmdHl), .cmdA(cmdA),
        .resValid(resValid), .resReady(resReady), .resBc(resBc), .resDe(resDe),
        .resHl(resHl), .resA(resA), .resF(resF), .busValid(busValid),
        .busReady(busReady), .busAddr(busAddr), .busWrite(busWrite), .busIo(busIo),
        .busWdata(busWdata), .busRdata(busRdata)
    );

    blockBusModel i_busModel (
        .clk(clk), .arstN(arstN), .busValid(busValid), .busAddr(busAddr),
        .busWrite(busWrite), .busIo(busIo), .busWdata(busWdata), .presetEn(presetEn),
        .presetAddr(presetAddr), .presetData(presetData), .busReady(busReady),
        .busRdata(busRdata)
    );

    // initial memory contents as loaded by the bus model.
    function automatic logic [7:0] patternByte(input logic [15:0] addr);
        return addr[15:8] ^ addr[7:0] ^ 8'h5A;
    endfunction

    task automatic compareValue(input string what, input logic [15:0] got,
                                input logic [15:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("error @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic expectTrue(input logic cond, input string what);
        checkCount++;
        assert (cond === 1'b1) else begin
            errorCount++;
            $display("error @%0t: %s", $time, what);
        end
    endtask

    task automatic addEntry(
        input logic [7:0] opc, input logic [15:0] bc, input logic [15:0] de,
        input logic [15:0] hl, input logic [7:0] a, input logic pEn,
        input logic [15:0] pAddr, input logic [7:0] pByte, input logic [15:0] expBc,
        input logic [15:0] expDe, input logic [15:0] expHl, input logic [7:0] expA,
        input logic [7:0] expF, input logic [1:0] kind, input logic [15:0] chkAddr,
        input logic [7:0] chkByte, input logic [7:0] copyLen
    );
        entries.push_back({opc, bc, de, hl, a, pEn, pAddr, pByte, expBc, expDe, expHl,
                           expA, expF, kind, chkAddr, chkByte, copyLen});
    endtask

    task automatic buildTable();
        addEntry(8'hA0, 16'h0005, 16'h2000, 16'h1000, 8'h11, 1'b0, 16'h0000, 8'h00,
                 16'h0004, 16'h2001, 16'h1001, 8'h11, 8'h04, CHK_MEM, 16'h2000, 8'h4A, 8'd1);
        addEntry(8'hA8, 16'h0001, 16'h2105, 16'h1105, 8'h22, 1'b0, 16'h0000, 8'h00,
                 16'h0000, 16'h2104, 16'h1104, 8'h22, 8'h00, CHK_MEM, 16'h2105, 8'h4E, 8'd1);
        addEntry(8'hB0, 16'h0010, 16'h2200, 16'h1200, 8'h33, 1'b0, 16'h0000, 8'h00,
                 16'h0000, 16'h2210, 16'h1210, 8'h33, 8'h00, CHK_MEM, 16'h220F, 8'h47, 8'd16);
        // CPIR with a match at the sixth byte, then one that runs out of count.
        addEntry(8'hB1, 16'h0020, 16'h3333, 16'h1300, 8'h4C, 1'b0, 16'h0000, 8'h00,
                 16'h001A, 16'h3333, 16'h1306, 8'h4C, 8'h46, CHK_MEM, 16'h1305, 8'h4C, 8'd0);
        addEntry(8'hB1, 16'h0004, 16'h3434, 16'h1400, 8'h00, 1'b0, 16'h0000, 8'h00,
                 16'h0000, 16'h3434, 16'h1404, 8'h00, 8'h92, CHK_NONE, 16'h0000, 8'h00, 8'd0);
        addEntry(8'hB2, 16'h0377, 16'h4444, 16'h1500, 8'h55, 1'b0, 16'h0000, 8'h00,
                 16'h0077, 16'h4444, 16'h1503, 8'h55, 8'h42, CHK_MEM, 16'h1502, 8'hD2, 8'd0);
        addEntry(8'hBB, 16'h0340, 16'h4545, 16'h1602, 8'h66, 1'b0, 16'h0000, 8'h00,
                 16'h0040, 16'h4545, 16'h15FF, 8'h66, 8'h42, CHK_IO, 16'h0002, 8'h4C, 8'd3);
        addEntry(8'hB9, 16'h0008, 16'h4646, 16'h1710, 8'hEE, 1'b1, 16'h170D, 8'hEE,
                 16'h0004, 16'h4646, 16'h170C, 8'hEE, 8'h46, CHK_MEM, 16'h170D, 8'hEE, 8'd0);
        addEntry(8'hA3, 16'h0190, 16'h4747, 16'h1800, 8'h77, 1'b0, 16'h0000, 8'h00,
                 16'h0090, 16'h4747, 16'h1801, 8'h77, 8'h42, CHK_IO, 16'h0000, 8'h42, 8'd1);
        addEntry(8'hAA, 16'h0533, 16'h4848, 16'h1905, 8'h88, 1'b0, 16'h0000, 8'h00,
                 16'h0433, 16'h4848, 16'h1904, 8'h88, 8'h02, CHK_MEM, 16'h1905, 8'h96, 8'd0);
        addEntry(8'hA1, 16'h0001, 16'h4949, 16'h1A00, 8'h50, 1'b0, 16'h0000, 8'h00,
                 16'h0000, 16'h4949, 16'h1A01, 8'h50, 8'h02, CHK_NONE, 16'h0000, 8'h00, 8'd0);
        // bit 2 set puts this opcode outside the block group.
        addEntry(8'hA4, 16'h1234, 16'h5678, 16'h9ABC, 8'h77, 1'b0, 16'h0000, 8'h00,
                 16'h1234, 16'h5678, 16'h9ABC, 8'h77, 8'h00, CHK_NONE, 16'h0000, 8'h00, 8'd0);
        addEntry(8'hB8, 16'h0003, 16'h2B02, 16'h1B02, 8'h99, 1'b0, 16'h0000, 8'h00,
                 16'h0000, 16'h2AFF, 16'h1AFF, 8'h99, 8'h00, CHK_MEM, 16'h2B00, 8'h41, 8'd3);
    endtask

    task automatic runEntry(input entryT e);
        logic [15:0] capBc, capDe, capHl, src, dst;
        logic [7:0]  capA, capF, ioBase;
        int          stall;
        int          i;
        if (e.presetEn) begin
            @(posedge clk);
            presetEn   <= 1'b1;
            presetAddr <= e.presetAddr;
            presetData <= e.presetByte;
            @(posedge clk);
            presetEn <= 1'b0;
        end
        ioBase = i_busModel.ioCount;
        @(posedge clk);
        cmdValid  <= 1'b1;
        cmdOpcode <= e.opcode;
        cmdBc     <= e.bc;
        cmdDe     <= e.de;
        cmdHl     <= e.hl;
        cmdA      <= e.a;
        @(negedge clk);
        while (!cmdReady) @(negedge clk);
        @(posedge clk);
        cmdValid <= 1'b0;
        @(negedge clk);
        while (!resValid) @(negedge clk);
        compareValue("BC", resBc, e.expBc);
        compareValue("DE", resDe, e.expDe);
        compareValue("HL", resHl, e.expHl);
        compareValue("A", {8'h00, resA}, {8'h00, e.expA});
        compareValue("F", {8'h00, resF}, {8'h00, e.expF});
        capBc = resBc;
        capDe = resDe;
        capHl = resHl;
        capA  = resA;
        capF  = resF;
        // hold the result back for a few cycles.
        stall = ($random(seed) & 3) + 1;
        repeat (stall) begin
            @(negedge clk);
            expectTrue(resValid && !cmdReady, "result handshake did not hold while stalled");
            expectTrue(resBc === capBc && resDe === capDe && resHl === capHl
                       && resA === capA && resF === capF, "result changed while stalled");
        end
        @(posedge clk);
        resReady <= 1'b1;
        @(posedge clk);
        resReady <= 1'b0;
        if (e.chkKind == CHK_MEM) begin
            compareValue("memory byte", i_busModel.mem[e.chkAddr], e.chkByte);
        end
        if (e.chkKind == CHK_IO) begin
            compareValue("IO log byte", i_busModel.ioLog[ioBase + e.chkAddr[7:0]], e.chkByte);
        end
        for (i = 0; i < e.copyLen; i++) begin
            src = e.opcode[3] ? e.hl - i : e.hl + i;
            dst = e.opcode[3] ? e.de - i : e.de + i;
            if (e.chkKind == CHK_IO) begin
                compareValue("IO log entry", i_busModel.ioLog[ioBase + i[7:0]], patternByte(src));
            end else begin
                compareValue("copied byte", i_busModel.mem[dst], patternByte(src));
            end
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        buildTable();
        cycleLimit = entries.size() * 64 * 3 * 5;
        @(posedge clk);
        @(negedge clk);
        expectTrue(!cmdReady && !resValid && !busValid, "outputs were not low during reset");
        wait (arstN === 1'b1);
        foreach (entries[i]) begin
            runEntry(entries[i]);
        end
        $display("summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
hw/blockOpPkg.sv
hw/blockStepDecoder.sv
hw/blockStepSequencer.sv
hw/blockRegUnit.sv
hw/blockBusPort.sv
hw/blockTransferUnit.sv
bench/blockClockGen.sv
bench/blockBusModel.sv
bench/blockTransferTb.sv

// ==== hw/blockBusPort.sv ====
// Memory and IO bus port
`timescale 1ns/1ps
`default_nettype none

`include "blockOp_consts.svh"

module blockBusPort (
    input  wire                    clk,
    input  wire                    arstN,
    input  wire blockOpPkg::busOpT busOp,
    input  wire blockOpPkg::wordT  addr,
    input  wire blockOpPkg::byteT  wdata,
    input  wire                    busReady,
    input  wire blockOpPkg::byteT  busRdata,
    output logic                   busValid,
    output blockOpPkg::wordT       busAddr,
    output logic                   busWrite,
    output logic                   busIo,
    output blockOpPkg::byteT       busWdata,
    output blockOpPkg::byteT       rdData,
    output logic                   opDone
);

    blockOpPkg::busStateT state;
    logic start;
    logic accepted;

    // the step is still current while opDone is high, so no new request then.
    assign start    = (state == blockOpPkg::BUS_IDLE) && (busOp != `BUSOP_NONE) && !opDone;
    assign accepted = (state == blockOpPkg::BUS_WAIT) && busReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= blockOpPkg::BUS_IDLE;
            busValid <= 1'b0;
            opDone   <= 1'b0;
        end else begin
            opDone <= accepted;
            if (start) begin
                state    <= blockOpPkg::BUS_WAIT;
                busValid <= 1'b1;
            end else if (accepted) begin
                state    <= blockOpPkg::BUS_IDLE;
                busValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            busAddr  <= addr;
            busWdata <= wdata;
            busWrite <= (busOp == `BUSOP_MEMWR) || (busOp == `BUSOP_IOWR);
            busIo    <= (busOp == `BUSOP_IORD) || (busOp == `BUSOP_IOWR);
        end
        if (accepted) begin
            rdData <= busRdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/blockOpPkg.sv ====
// Block instruction types
`default_nettype none

`include "blockOp_consts.svh"

package blockOpPkg;

    // plain data widths.
    typedef logic [7:0]  byteT;
    typedef logic [15:0] wordT;

    // the opcode byte that follows the ED prefix.
    typedef logic [7:0] opcodeT;

    typedef logic [`BLK_STEP_W-1:0]  stepT;
    typedef logic [`BLK_BUSOP_W-1:0] busOpT;

    // command sequencer states.
    typedef enum logic [1:0] {
        SEQ_IDLE = 2'd0,
        SEQ_RUN  = 2'd1,
        SEQ_DONE = 2'd2
    } seqStateT;

    // bus port states.
    typedef enum logic {
        BUS_IDLE = 1'b0,
        BUS_WAIT = 1'b1
    } busStateT;

endpackage

`default_nettype wire

// ==== hw/blockRegUnit.sv ====
// Block register file and flags
`timescale 1ns/1ps
`default_nettype none

`include "blockOp_consts.svh"

module blockRegUnit (
    input  wire                   clk,
    input  wire                   arstN,
    input  wire                   loadRegs,
    input  wire blockOpPkg::wordT cmdBc,
    input  wire blockOpPkg::wordT cmdDe,
    input  wire blockOpPkg::wordT cmdHl,
    input  wire blockOpPkg::byteT cmdA,
    input  wire blockOpPkg::byteT rdData,
    input  wire                   dirDown,
    input  wire                   addrSelHl,
    input  wire                   addrSelDe,
    input  wire                   addrSelBc,
    input  wire                   dataSelA,
    input  wire                   dataSelLatch,
    input  wire                   latchWrite,
    input  wire                   writeBc,
    input  wire                   writeB,
    input  wire                   writeDe,
    input  wire                   writeHl,
    input  wire                   flagWriteLd,
    input  wire                   flagWriteCp,
    input  wire                   flagWriteIo,
    output blockOpPkg::wordT      addr,
    output blockOpPkg::byteT      wdata,
    output logic                  flagPv,
    output logic                  flagZ,
    output blockOpPkg::wordT      resBc,
    output blockOpPkg::wordT      resDe,
    output blockOpPkg::wordT      resHl,
    output blockOpPkg::byteT      resA,
    output blockOpPkg::byteT      resF
);

    blockOpPkg::wordT bc, de, hl;
    blockOpPkg::byteT a, f;
    blockOpPkg::byteT latchData;
    blockOpPkg::wordT ptrStep;
    blockOpPkg::wordT bcDec;
    blockOpPkg::byteT aluHigh, aluLow, aluOut;
    logic halfBorrow;

    assign addr = ({16{addrSelHl}} & hl)
                | ({16{addrSelDe}} & de)
                | ({16{addrSelBc}} & bc);
    assign wdata = latchData;

    // HL and DE move by +1 or -1 together.
    assign ptrStep = dirDown ? 16'hFFFF : 16'h0001;
    assign bcDec   = bc - 16'h0001;

    // A minus the data byte for compares, B minus one for the IO group.
    assign aluHigh    = dataSelA ? a : bc[15:8];
    assign aluLow     = dataSelLatch ? latchData : 8'h01;
    assign aluOut     = aluHigh - aluLow;
    assign halfBorrow = aluHigh[4] ^ aluLow[4] ^ aluOut[4];

    // both flags look at the values about to be written, so the decoder can decide now.
    assign flagPv = (bcDec != 16'h0000);
    assign flagZ  = (aluOut == 8'h00);

    always_ff @(posedge clk) begin
        if (latchWrite) begin
            latchData <= rdData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bc <= '0;
            de <= '0;
            hl <= '0;
            a  <= '0;
            f  <= '0;
        end else if (loadRegs) begin
            bc <= cmdBc;
            de <= cmdDe;
            hl <= cmdHl;
            a  <= cmdA;
            f  <= '0;
        end else begin
            if (writeBc) bc <= bcDec;
            if (writeB) bc[15:8] <= aluOut;
            if (writeDe) de <= de + ptrStep;
            if (writeHl) hl <= hl + ptrStep;
            if (flagWriteLd) begin
                f[`FLAG_H]  <= 1'b0;
                f[`FLAG_N]  <= 1'b0;
                f[`FLAG_PV] <= flagPv;
            end
            if (flagWriteCp) begin
                f[`FLAG_S]  <= aluOut[7];
                f[`FLAG_Z]  <= flagZ;
                f[`FLAG_H]  <= halfBorrow;
                f[`FLAG_N]  <= 1'b1;
                f[`FLAG_PV] <= flagPv;
            end
            if (flagWriteIo) begin
                f[`FLAG_Z] <= flagZ;
                f[`FLAG_N] <= 1'b1;
            end
        end
    end

    assign resBc = bc;
    assign resDe = de;
    assign resHl = hl;
    assign resA  = a;
    assign resF  = f;

endmodule

`default_nettype wire

// ==== hw/blockStepDecoder.sv ====
// Block opcode step decoder
`timescale 1ns/1ps
`default_nettype none

`include "blockOp_consts.svh"

module blockStepDecoder (
    input  wire                enable,
    input  wire blockOpPkg::opcodeT opcode,
    input  wire blockOpPkg::stepT   step,
    input  wire                flagPv,
    input  wire                flagZ,
    output blockOpPkg::busOpT  busOp,
    output logic               addrSelHl,
    output logic               addrSelDe,
    output logic               addrSelBc,
    output logic               dataSelA,
    output logic               dataSelLatch,
    output logic               latchWrite,
    output logic               writeBc,
    output logic               writeB,
    output logic               writeDe,
    output logic               writeHl,
    output logic               flagWriteLd,
    output logic               flagWriteCp,
    output logic               flagWriteIo,
    output logic               stepReset,
    output logic               finish
);

    logic valid;
    logic rep;
    logic isLd;
    logic isCp;
    logic isIn;
    logic isOut;
    logic atBus0;
    logic atBus1;
    logic atUpdate;
    logic ldRd, ldWr, ldUpd;
    logic cpRd, cpUpd;
    logic inRd, inWr, inUpd;
    logic outRd, outWr, outUpd;
    logic memRd, memWr, ioRd, ioWr;
    logic anyUpd;
    logic cont;

    // only 101x x0xx belongs to the block group.
    assign valid = (opcode[7:5] == 3'b101) && !opcode[2];
    assign rep   = opcode[4];

    // one-hot group select on gg.
    assign isLd  = enable && valid && (opcode[1:0] == 2'b00);
    assign isCp  = enable && valid && (opcode[1:0] == 2'b01);
    assign isIn  = enable && valid && (opcode[1:0] == 2'b10);
    assign isOut = enable && valid && (opcode[1:0] == 2'b11);

    assign atBus0   = (step == `STEP_BUS0);
    assign atBus1   = (step == `STEP_BUS1);
    assign atUpdate = (step == `STEP_UPDATE);

    // LD reads (HL) then writes (DE).
    assign ldRd  = isLd && atBus0;
    assign ldWr  = isLd && atBus1;
    assign ldUpd = isLd && atUpdate;

    // CP only reads (HL); step 1 is an idle slot.
    assign cpRd  = isCp && atBus0;
    assign cpUpd = isCp && atUpdate;

    // IN reads port (BC) then writes (HL).
    assign inRd  = isIn && atBus0;
    assign inWr  = isIn && atBus1;
    assign inUpd = isIn && atUpdate;

    // OUT reads (HL) then writes port (BC).
    assign outRd  = isOut && atBus0;
    assign outWr  = isOut && atBus1;
    assign outUpd = isOut && atUpdate;

    assign memRd = ldRd | cpRd | outRd;
    assign memWr = ldWr | inWr;
    assign ioRd  = inRd;
    assign ioWr  = outWr;

    assign busOp = ({`BLK_BUSOP_W{memRd}} & `BUSOP_MEMRD)
                 | ({`BLK_BUSOP_W{memWr}} & `BUSOP_MEMWR)
                 | ({`BLK_BUSOP_W{ioRd}}  & `BUSOP_IORD)
                 | ({`BLK_BUSOP_W{ioWr}}  & `BUSOP_IOWR);

    assign addrSelHl  = ldRd | cpRd | inWr | outRd;
    assign addrSelDe  = ldWr;
    assign addrSelBc  = inRd | outWr;
    assign latchWrite = ldRd | cpRd | inRd | outRd;

    // the compare runs A against the latched byte, otherwise the ALU does B - 1.
    assign dataSelA     = cpUpd;
    assign dataSelLatch = cpUpd;

    assign writeBc = ldUpd | cpUpd;
    assign writeB  = inUpd | outUpd;
    assign writeDe = ldUpd;
    assign writeHl = ldUpd | cpUpd | inUpd | outUpd;

    assign flagWriteLd = ldUpd;
    assign flagWriteCp = cpUpd;
    assign flagWriteIo = inUpd | outUpd;

    assign anyUpd = writeHl;
    assign cont   = (ldUpd & flagPv)
                  | (cpUpd & flagPv & ~flagZ)
                  | ((inUpd | outUpd) & ~flagZ);

    assign stepReset = rep & cont;
    assign finish    = (anyUpd & ~stepReset) | (enable & ~valid & atBus0);

endmodule

`default_nettype wire

// ==== hw/blockStepSequencer.sv ====
// Block command sequencer
`timescale 1ns/1ps
`default_nettype none

`include "blockOp_consts.svh"

module blockStepSequencer (
    input  wire                     clk,
    input  wire                     arstN,
    input  wire                     cmdValid,
    input  wire blockOpPkg::opcodeT cmdOpcode,
    input  wire blockOpPkg::busOpT  busOp,
    input  wire                     opDone,
    input  wire                     stepReset,
    input  wire                     finish,
    input  wire                     resReady,
    output logic                    cmdReady,
    output logic                    resValid,
    output logic                    enable,
    output blockOpPkg::opcodeT      opcode,
    output blockOpPkg::stepT        step,
    output logic                    loadRegs
);

    blockOpPkg::seqStateT state;
    blockOpPkg::seqStateT nextState;
    logic accept;
    logic advance;

    assign accept   = cmdValid && cmdReady;
    assign loadRegs = accept;
    assign enable   = (state == blockOpPkg::SEQ_RUN);
    assign resValid = (state == blockOpPkg::SEQ_DONE);

    // a bus step waits for its completion, any other step takes one cycle.
    assign advance = (busOp == `BUSOP_NONE) || opDone;

    always_comb begin
        nextState = state;
        case (state)
            blockOpPkg::SEQ_IDLE: if (accept) nextState = blockOpPkg::SEQ_RUN;
            blockOpPkg::SEQ_RUN:  if (finish) nextState = blockOpPkg::SEQ_DONE;
            blockOpPkg::SEQ_DONE: if (resReady) nextState = blockOpPkg::SEQ_IDLE;
            default:              nextState = blockOpPkg::SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= blockOpPkg::SEQ_IDLE;
            cmdReady <= 1'b0;
            step     <= '0;
        end else begin
            state    <= nextState;
            // registered so that it stays low through reset.
            cmdReady <= (nextState == blockOpPkg::SEQ_IDLE);
            if (accept || stepReset) begin
                step <= '0;
            end else if (enable && !finish && advance) begin
                step <= step + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opcode <= cmdOpcode;
        end
    end

endmodule

`default_nettype wire

// ==== hw/blockTransferUnit.sv ====
// Block transfer unit top
`timescale 1ns/1ps
`default_nettype none

module blockTransferUnit (
    input  wire                     clk,
    input  wire                     arstN,
    input  wire                     cmdValid,
    output logic                    cmdReady,
    input  wire blockOpPkg::opcodeT cmdOpcode,
    input  wire blockOpPkg::wordT   cmdBc,
    input  wire blockOpPkg::wordT   cmdDe,
    input  wire blockOpPkg::wordT   cmdHl,
    input  wire blockOpPkg::byteT   cmdA,
    output logic                    resValid,
    input  wire                     resReady,
    output blockOpPkg::wordT        resBc,
    output blockOpPkg::wordT        resDe,
    output blockOpPkg::wordT        resHl,
    output blockOpPkg::byteT        resA,
    output blockOpPkg::byteT        resF,
    output logic                    busValid,
    input  wire                     busReady,
    output blockOpPkg::wordT        busAddr,
    output logic                    busWrite,
    output logic                    busIo,
    output blockOpPkg::byteT        busWdata,
    input  wire blockOpPkg::byteT   busRdata
);

    blockOpPkg::opcodeT opcode;
    blockOpPkg::stepT   step;
    blockOpPkg::busOpT  busOp;
    blockOpPkg::wordT   addr;
    blockOpPkg::byteT   wdata;
    blockOpPkg::byteT   rdData;
    logic enable, loadRegs, opDone, stepReset, finish;
    logic flagPv, flagZ;
    logic addrSelHl, addrSelDe, addrSelBc, dataSelA, dataSelLatch;
    logic latchWrite, writeBc, writeB, writeDe, writeHl;
    logic flagWriteLd, flagWriteCp, flagWriteIo;

    blockStepSequencer i_seq (
        .clk(clk), .arstN(arstN), .cmdValid(cmdValid), .cmdOpcode(cmdOpcode),
        .busOp(busOp), .opDone(opDone), .stepReset(stepReset), .finish(finish),
        .resReady(resReady), .cmdReady(cmdReady), .resValid(resValid),
        .enable(enable), .opcode(opcode), .step(step), .loadRegs(loadRegs)
    );

    blockStepDecoder i_dec (
        .enable(enable), .opcode(opcode), .step(step), .flagPv(flagPv), .flagZ(flagZ),
        .busOp(busOp), .addrSelHl(addrSelHl), .addrSelDe(addrSelDe),
        .addrSelBc(addrSelBc), .dataSelA(dataSelA), .dataSelLatch(dataSelLatch),
        .latchWrite(latchWrite), .writeBc(writeBc), .writeB(writeB),
        .writeDe(writeDe), .writeHl(writeHl), .flagWriteLd(flagWriteLd),
        .flagWriteCp(flagWriteCp), .flagWriteIo(flagWriteIo),
        .stepReset(stepReset), .finish(finish)
    );

    // opcode bit 3 selects the decrementing variants.
    blockRegUnit i_regs (
        .clk(clk), .arstN(arstN), .loadRegs(loadRegs), .cmdBc(cmdBc), .cmdDe(cmdDe),
        .cmdHl(cmdHl), .cmdA(cmdA), .rdData(rdData), .dirDown(opcode[3]),
        .addrSelHl(addrSelHl), .addrSelDe(addrSelDe), .addrSelBc(addrSelBc),
        .dataSelA(dataSelA), .dataSelLatch(dataSelLatch), .latchWrite(latchWrite),
        .writeBc(writeBc), .writeB(writeB), .writeDe(writeDe), .writeHl(writeHl),
        .flagWriteLd(flagWriteLd), .flagWriteCp(flagWriteCp), .flagWriteIo(flagWriteIo),
        .addr(addr), .wdata(wdata), .flagPv(flagPv), .flagZ(flagZ),
        .resBc(resBc), .resDe(resDe), .resHl(resHl), .resA(resA), .resF(resF)
    );

    blockBusPort i_bus (
        .clk(clk), .arstN(arstN), .busOp(busOp), .addr(addr), .wdata(wdata),
        .busReady(busReady), .busRdata(busRdata), .busValid(busValid),
        .busAddr(busAddr), .busWrite(busWrite), .busIo(busIo),
        .busWdata(busWdata), .rdData(rdData), .opDone(opDone)
    );

endmodule

`default_nettype wire

// ==== include/blockOp_consts.svh ====
// Block instruction constants
`ifndef BLOCKOP_CONSTS_SVH
`define BLOCKOP_CONSTS_SVH

`define BLK_STEP_W      3
`define BLK_BUSOP_W     3

`define BUSOP_NONE      3'd0
`define BUSOP_MEMRD     3'd1
`define BUSOP_MEMWR     3'd2
`define BUSOP_IORD      3'd3
`define BUSOP_IOWR      3'd4

`define STEP_BUS0       3'd0
`define STEP_BUS1       3'd1
`define STEP_UPDATE     3'd2

`define FLAG_S          7
`define FLAG_Z          6
`define FLAG_H          4
`define FLAG_PV         2
`define FLAG_N          1
`define FLAG_C          0

`endif
